/* verilog/wbm_pkg.sv */
//----------------------------------------------------------
// shared types and constants of the wishbone stream master
// every word is 32 bits wide, FIFO depths must be powers of two
// command type code 3 is treated as a plain read
//----------------------------------------------------------
`default_nettype none

package wbm_pkg;

    typedef logic [31:0] word_t;  // data, address and command words share one width

    // decoded operation of the current record
    typedef enum logic [1:0] {
        CMD_READ  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_RMW   = 2'd2   // read, merge under mask, write back
    } cmd_kind_e;

    //------------------------------------------------------
    // command word fields
    //------------------------------------------------------
    localparam int CMD_TYPE_LSB = 0;
    localparam int CMD_TYPE_MSB = 1;
    localparam int CMD_ID_LSB   = 15;  // the id only travels back inside the echo word
    localparam int CMD_ID_MSB   = 22;

    //------------------------------------------------------
    // record and buffer sizes
    //------------------------------------------------------
    // in: command, address, mask, data
    // out: echo, data, address, result
    localparam int RECORD_WORDS = 4;
    localparam int FIFO_DEPTH   = 16;

    // a cycle is abandoned once stb has been high this long without ack
    localparam int TIMEOUT_CYCLES = 100;
    localparam int TIMER_W        = $clog2(TIMEOUT_CYCLES);  // holds 0 .. TIMEOUT_CYCLES-1

    //------------------------------------------------------
    // result record
    //------------------------------------------------------
    localparam word_t WRITE_FILLER     = 32'hdeadbeef;  // data word sent back for writes
    localparam int RESULT_TIMEOUT_BIT  = 0;             // all other result bits stay zero

endpackage

`default_nettype wire

/* verilog/wbm_ifs.sv */
//----------------------------------------------------------
// internal bundles between the register block, the sequencer
// and the bus cycle engine, at most one bus request is in flight
//----------------------------------------------------------
`default_nettype none

// decoded command record, held until the sequencer releases it
interface cmd_if import wbm_pkg::*; ();
    logic      cmd_valid;    // high from the fourth word until the cycle after release
    word_t     cmd_word;     // raw command word, echoed unchanged
    cmd_kind_e kind;
    word_t     address;
    word_t     mask;
    word_t     data;
    logic      cmd_release;  // one-cycle pulse once the result word is out

    modport regs (output cmd_valid, cmd_word, kind, address, mask, data, input cmd_release);
    modport seq (input cmd_valid, cmd_word, kind, address, mask, data, output cmd_release);
endinterface

// one bus transaction request and its completion
interface wb_req_if import wbm_pkg::*; ();
    logic  req;        // one-cycle pulse, fields below sampled with it
    logic  we;
    word_t adr;
    word_t wdat;
    logic  done;       // one-cycle pulse at the end of the cycle
    word_t rdat;       // read data, zero after a timeout
    logic  timed_out;  // valid together with done

    modport seq (output req, we, adr, wdat, input done, rdat, timed_out);
    modport bus (input req, we, adr, wdat, output done, rdat, timed_out);
endinterface

`default_nettype wire

/* verilog/word_fifo.sv */
//----------------------------------------------------------
// synchronous valid/ready FIFO of 32-bit words
// DEPTH must be a power of two, pop data is read from the array
// combinationally, a pushed word shows on the pop side next cycle
//----------------------------------------------------------
`default_nettype none

module word_fifo import wbm_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic  wb_clk,
    input  logic  wb_rst,
    input  logic  push_valid_i,
    input  word_t push_data_i,
    output logic  push_ready_o,
    output logic  pop_valid_o,
    output word_t pop_data_o,
    input  logic  pop_ready_i
);

    localparam int AW = $clog2(DEPTH);

    word_t          mem [DEPTH];
    logic [AW-1:0]  wr_ptr;  // wraps naturally since DEPTH is a power of two
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;   // one extra bit so that a full FIFO is distinct from empty
    logic           push_fire;
    logic           pop_fire;

    // full and empty are only ever decided here
    assign push_ready_o = (count != (AW + 1)'(DEPTH));
    assign pop_valid_o  = (count != '0);
    assign pop_data_o   = mem[rd_ptr];

    assign push_fire = push_valid_i && push_ready_o;
    assign pop_fire  = pop_valid_o && pop_ready_i;

    // storage array
    always_ff @(posedge wb_clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    //------------------------------------------------------
    // pointers and fill level
    //------------------------------------------------------
    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) wr_ptr <= wr_ptr + 1'b1;
            if (pop_fire) rd_ptr <= rd_ptr + 1'b1;
            // simultaneous push and pop leave the level unchanged
            if (push_fire && !pop_fire) begin
                count <= count + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cmd_regs.sv */
//----------------------------------------------------------
// command register block, gathers command, address, mask and
// data from the input FIFO and holds them until released
// no new word is taken while a record is pending
//----------------------------------------------------------
`default_nettype none

module cmd_regs import wbm_pkg::*; (
    input  logic  wb_clk,
    input  logic  wb_rst,
    input  logic  in_valid_i,
    input  word_t in_data_i,
    output logic  in_ready_o,
    cmd_if.regs   cmd
);

    logic [1:0] word_idx;  // position of the next word inside the record
    logic       take;

    // type code 3 has no operation of its own and runs as a read
    function automatic cmd_kind_e decode_kind(input logic [1:0] code);
        cmd_kind_e k;
        unique case (code)
            2'd1:    k = CMD_WRITE;
            2'd2:    k = CMD_RMW;
            default: k = CMD_READ;
        endcase
        return k;
    endfunction

    assign in_ready_o = !cmd.cmd_valid;  // hold off the FIFO while a record is pending
    assign take       = in_valid_i && in_ready_o;

    // control state, index and record flag
    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            word_idx      <= '0;
            cmd.cmd_valid <= 1'b0;
        end else begin
            if (take) begin
                word_idx <= word_idx + 1'b1;  // wraps back to the command slot
                if (word_idx == 2'(RECORD_WORDS - 1)) cmd.cmd_valid <= 1'b1;
            end
            if (cmd.cmd_release) cmd.cmd_valid <= 1'b0;
        end
    end

    //------------------------------------------------------
    // payload registers, steered by the word index
    //------------------------------------------------------
    always_ff @(posedge wb_clk) begin
        if (take) begin
            unique case (word_idx)
                2'd0: cmd.cmd_word <= in_data_i;
                2'd1: cmd.address  <= in_data_i;
                2'd2: cmd.mask     <= in_data_i;
                default: begin
                    cmd.data <= in_data_i;
                    // command word already sits in its register by now
                    cmd.kind <= decode_kind(cmd.cmd_word[CMD_TYPE_MSB:CMD_TYPE_LSB]);
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/wb_cycle.sv */
//----------------------------------------------------------
// one Wishbone classic cycle per request, cyc and stb rise the
// edge after req and fall on ack or after TIMEOUT_CYCLES cycles
// a new req is only accepted while the bus is idle
//----------------------------------------------------------
`default_nettype none

module wb_cycle import wbm_pkg::*; (
    input  logic  wb_clk,
    input  logic  wb_rst,
    wb_req_if.bus req,
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output logic  wb_we_o,
    output word_t wb_adr_o,
    output word_t wb_dat_o,
    input  word_t wb_dat_i,
    input  logic  wb_ack_i
);

    logic               active;  // a cycle is on the bus
    logic [TIMER_W-1:0] timer;   // cycles spent with stb high so far

    assign wb_cyc_o = active;  // single transfers, so cyc and stb move together
    assign wb_stb_o = active;

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            active        <= 1'b0;
            req.done      <= 1'b0;
            req.timed_out <= 1'b0;
        end else begin
            req.done <= 1'b0;  // done is a single pulse
            if (!active && req.req) begin
                active <= 1'b1;
            end else if (active && wb_ack_i) begin
                active        <= 1'b0;
                req.done      <= 1'b1;
                req.timed_out <= 1'b0;
            end else if (active && timer == TIMER_W'(TIMEOUT_CYCLES - 1)) begin
                // the slave never answered, give the bus up
                active        <= 1'b0;
                req.done      <= 1'b1;
                req.timed_out <= 1'b1;
            end
        end
    end

    //------------------------------------------------------
    // bus fields, timer and read capture
    //------------------------------------------------------
    always_ff @(posedge wb_clk) begin
        if (!active && req.req) begin
            wb_we_o  <= req.we;
            wb_adr_o <= req.adr;
            wb_dat_o <= req.wdat;
            timer    <= '0;
        end else if (active) begin
            timer <= timer + 1'b1;
            if (wb_ack_i) req.rdat <= wb_dat_i;
            else if (timer == TIMER_W'(TIMEOUT_CYCLES - 1)) req.rdat <= '0;  // no data arrived
        end
    end

endmodule

`default_nettype wire

/* verilog/txn_sequencer.sv */
//----------------------------------------------------------
// transaction sequencer, runs the bus cycles of one record and
// pushes the four result words, a timed out read skips the
// merge write of a read-modify-write
//----------------------------------------------------------
`default_nettype none

module txn_sequencer import wbm_pkg::*; (
    input  logic   wb_clk,
    input  logic   wb_rst,
    cmd_if.seq     cmd,
    wb_req_if.seq  bus,
    output logic   out_valid_o,
    output word_t  out_data_o,
    input  logic   out_ready_i
);

    typedef enum logic [3:0] {
        WAIT_CMD,
        ISSUE_FIRST,   // read, or the write of a plain write
        WAIT_FIRST,
        ISSUE_MERGE,   // write back of a read-modify-write
        WAIT_MERGE,
        PUSH_ECHO,
        PUSH_DATA,
        PUSH_ADDR,
        PUSH_RESULT
    } state_e;

    state_e state;
    logic   timeout_flag;  // any bus cycle of this record timed out
    word_t  rd_data;       // read data of the first cycle
    word_t  merged;
    word_t  result;

    // new data = (old data AND NOT mask) OR (data AND mask)
    assign merged = (rd_data & ~cmd.mask) | (cmd.data & cmd.mask);

    //------------------------------------------------------
    // request side, sampled by the bus engine with req
    //------------------------------------------------------
    assign bus.req  = (state == ISSUE_FIRST) || (state == ISSUE_MERGE);
    assign bus.we   = (state == ISSUE_MERGE) || (cmd.kind == CMD_WRITE);
    assign bus.adr  = cmd.address;
    assign bus.wdat = (state == ISSUE_MERGE) ? merged : cmd.data;

    // the registers are freed together with the last output word
    assign cmd.cmd_release = (state == PUSH_RESULT) && out_ready_i;

    //------------------------------------------------------
    // output words, steady for as long as the FIFO stalls
    //------------------------------------------------------
    always_comb begin
        result                     = '0;
        result[RESULT_TIMEOUT_BIT] = timeout_flag;
        out_valid_o = 1'b1;
        unique case (state)
            PUSH_ECHO: out_data_o = cmd.cmd_word;  // id field included
            PUSH_DATA: out_data_o = (cmd.kind == CMD_WRITE) ? WRITE_FILLER : rd_data;
            PUSH_ADDR: out_data_o = cmd.address;
            PUSH_RESULT: out_data_o = result;
            default: begin
                out_valid_o = 1'b0;
                out_data_o  = '0;
            end
        endcase
    end

    //------------------------------------------------------
    // state machine
    //------------------------------------------------------
    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            state        <= WAIT_CMD;
            timeout_flag <= 1'b0;
        end else begin
            unique case (state)
                WAIT_CMD: begin
                    timeout_flag <= 1'b0;  // every record starts clean
                    if (cmd.cmd_valid) state <= ISSUE_FIRST;
                end
                ISSUE_FIRST: state <= WAIT_FIRST;  // req lasts exactly this cycle
                WAIT_FIRST: begin
                    if (bus.done) begin
                        if (bus.timed_out) timeout_flag <= 1'b1;
                        if (cmd.kind == CMD_RMW && !bus.timed_out) state <= ISSUE_MERGE;
                        else state <= PUSH_ECHO;
                    end
                end
                ISSUE_MERGE: state <= WAIT_MERGE;
                WAIT_MERGE: begin
                    if (bus.done) begin
                        if (bus.timed_out) timeout_flag <= 1'b1;
                        state <= PUSH_ECHO;
                    end
                end
                PUSH_ECHO: if (out_ready_i) state <= PUSH_DATA;
                PUSH_DATA: if (out_ready_i) state <= PUSH_ADDR;
                PUSH_ADDR: if (out_ready_i) state <= PUSH_RESULT;
                PUSH_RESULT: if (out_ready_i) state <= WAIT_CMD;
                default: state <= WAIT_CMD;
            endcase
        end
    end

    // first cycle read data, the merge write leaves it alone so the old value goes out
    always_ff @(posedge wb_clk) begin
        if (state == WAIT_FIRST && bus.done) rd_data <= bus.rdat;
    end

endmodule

`default_nettype wire

/* verilog/wb_master_top.sv */
//----------------------------------------------------------
// Wishbone classic master fed by a word stream, records of four
// words in and four words out, all on wb_clk
// the delay from a record to its result depends on the slave
//----------------------------------------------------------
`default_nettype none

module wb_master_top import wbm_pkg::*; (
    input  logic  wb_clk,
    input  logic  wb_rst,
    // command stream from the host
    input  logic  in_valid_i,
    input  word_t in_data_i,
    output logic  in_ready_o,
    // result stream to the host
    output logic  out_valid_o,
    output word_t out_data_o,
    input  logic  out_ready_i,
    // Wishbone master
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output logic  wb_we_o,
    output word_t wb_adr_o,
    output word_t wb_dat_o,
    input  word_t wb_dat_i,
    input  logic  wb_ack_i
);

    logic  in_pop_valid;   // input FIFO towards the register block
    word_t in_pop_data;
    logic  in_pop_ready;
    logic  res_valid;      // sequencer towards the output FIFO
    word_t res_data;
    logic  res_ready;

    cmd_if    cmd_bus ();
    wb_req_if req_bus ();

    //------------------------------------------------------
    // stream buffering
    //------------------------------------------------------
    word_fifo u_in_fifo (
        .wb_clk(wb_clk), .wb_rst(wb_rst),
        .push_valid_i(in_valid_i), .push_data_i(in_data_i), .push_ready_o(in_ready_o),
        .pop_valid_o(in_pop_valid), .pop_data_o(in_pop_data), .pop_ready_i(in_pop_ready)
    );

    word_fifo u_out_fifo (
        .wb_clk(wb_clk), .wb_rst(wb_rst),
        .push_valid_i(res_valid), .push_data_i(res_data), .push_ready_o(res_ready),
        .pop_valid_o(out_valid_o), .pop_data_o(out_data_o), .pop_ready_i(out_ready_i)
    );

    //------------------------------------------------------
    // record handling and bus access
    //------------------------------------------------------
    cmd_regs u_cmd_regs (
        .wb_clk(wb_clk), .wb_rst(wb_rst),
        .in_valid_i(in_pop_valid), .in_data_i(in_pop_data), .in_ready_o(in_pop_ready),
        .cmd(cmd_bus.regs)
    );

    txn_sequencer u_txn_sequencer (
        .wb_clk(wb_clk), .wb_rst(wb_rst),
        .cmd(cmd_bus.seq), .bus(req_bus.seq),
        .out_valid_o(res_valid), .out_data_o(res_data), .out_ready_i(res_ready)
    );

    wb_cycle u_wb_cycle (
        .wb_clk(wb_clk), .wb_rst(wb_rst), .req(req_bus.bus),
        .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
        .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
    );

endmodule

`default_nettype wire

/* tb/wb_mem_model.sv */
//----------------------------------------------------------
// Wishbone classic slave memory for simulation, 256 words
// indexed by address bits 9 to 2, ack one cycle after stb
// an address with bit 31 set is never acknowledged
//----------------------------------------------------------
`default_nettype none

module wb_mem_model import wbm_pkg::*; (
    input  logic  wb_clk,
    input  logic  wb_rst,
    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    input  logic  wb_we_i,
    input  word_t wb_adr_i,
    input  word_t wb_dat_i,
    output word_t wb_dat_o,
    output logic  wb_ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t      mem [256];
    logic [7:0] idx;
    logic       unmapped;  // this slot hangs the bus

    assign idx      = wb_adr_i[9:2];
    assign unmapped = wb_adr_i[31];

    // every word differs in all four bytes, so a wrong index shows up at once
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h33};
        end
    end

    always @(posedge wb_clk) begin
        if (wb_rst) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0;  // single cycle ack, dropped while stb is still seen high
            if (wb_cyc_i && wb_stb_i && !wb_ack_o && !unmapped) begin
                wb_ack_o <= 1'b1;
                if (wb_we_i) mem[idx] <= wb_dat_i;
                wb_dat_o <= mem[idx];  // old value, the write lands on the same edge
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_wb_master.sv */
//----------------------------------------------------------
// testbench of the Wishbone stream master, directed records
// first, then random records with random output stalls
// stops at the first mismatch, limited to MAX_CYCLES cycles
//----------------------------------------------------------
`default_nettype none

module tb_wb_master import wbm_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 10;
    localparam int DRIVE_DELAY    = 2;
    localparam int RANDOM_RECORDS = 52;      // 8 directed records come before these
    localparam int MAX_CYCLES     = 20_000;  // 60 records of about 112 cycles each, plus stalls

    logic  wb_clk;
    logic  wb_rst;
    logic  in_valid_i;
    word_t in_data_i;
    logic  in_ready_o;
    logic  out_valid_o;
    word_t out_data_o;
    logic  out_ready_i;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    word_t wb_adr;
    word_t wb_wdat;
    word_t wb_rdat;
    logic  wb_ack;

    integer seed = 32'hbf88;
    word_t  exp_q [$];     // expected output words in stream order
    word_t  mirror [256];  // what the slave memory should hold
    int     words_pushed;
    int     words_checked;
    int     cycle_count;

    wb_master_top UUT (
        .wb_clk(wb_clk), .wb_rst(wb_rst),
        .in_valid_i(in_valid_i), .in_data_i(in_data_i), .in_ready_o(in_ready_o),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o), .out_ready_i(out_ready_i),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_wdat), .wb_dat_i(wb_rdat), .wb_ack_i(wb_ack)
    );

    wb_mem_model u_slave (
        .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
        .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat), .wb_dat_o(wb_rdat),
        .wb_ack_o(wb_ack)
    );

    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    //------------------------------------------------------
    // expected record from the command rules
    //------------------------------------------------------
    function automatic logic [127:0] reference_record(input word_t cmd_w, input word_t adr,
                                                      input word_t msk, input word_t dat);
        logic [1:0] code;
        logic       hang;
        logic [7:0] idx;
        word_t      old;
        word_t      data_w;
        word_t      res;
        code = cmd_w[CMD_TYPE_MSB:CMD_TYPE_LSB];
        hang = adr[31];                  // such a cycle times out and reads zero
        idx  = adr[9:2];
        old  = hang ? '0 : mirror[idx];
        res  = '0;
        res[RESULT_TIMEOUT_BIT] = hang;
        data_w = old;                    // code 3 falls through as a read
        if (code == 2'd1) begin
            data_w = WRITE_FILLER;
            if (!hang) mirror[idx] = dat;
        end else if (code == 2'd2 && !hang) begin
            mirror[idx] = (old & ~msk) | (dat & msk);
        end
        return {cmd_w, data_w, adr, res};
    endfunction

    function automatic word_t make_cmd(input logic [1:0] code, input logic [7:0] id,
                                       input word_t noise);
        word_t w;
        w = noise;  // the other bits must come back unchanged in the echo
        w[CMD_ID_MSB:CMD_ID_LSB]     = id;
        w[CMD_TYPE_MSB:CMD_TYPE_LSB] = code;
        return w;
    endfunction

    function automatic string field_name(input int pos);
        case (pos)
            0:       return "out_data_o echo";
            1:       return "out_data_o data";
            2:       return "out_data_o address";
            default: return "out_data_o result";
        endcase
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    // called just after a drive point, returns at the next one
    task automatic push_word(input word_t w);
        logic fire;
        in_valid_i = 1'b1;
        in_data_i  = w;
        fire       = 1'b0;
        while (!fire) begin
            @(negedge wb_clk);
            fire = in_ready_o;  // stable here, the handshake completes at the next edge
            @(posedge wb_clk);
        end
        #DRIVE_DELAY;
        in_valid_i = 1'b0;
    endtask

    task automatic push_record(input word_t cmd_w, input word_t adr,
                               input word_t msk, input word_t dat);
        logic [127:0] exp;
        exp = reference_record(cmd_w, adr, msk, dat);
        for (int i = 3; i >= 0; i--) exp_q.push_back(exp[i*32 +: 32]);
        push_word(cmd_w);
        push_word(adr);
        push_word(msk);
        push_word(dat);
        words_pushed += RECORD_WORDS;
    endtask

    //------------------------------------------------------
    // output stalls, drawn at the falling edge
    //------------------------------------------------------
    initial begin
        logic ready_draw;
        out_ready_i = 1'b1;
        forever begin
            @(negedge wb_clk);
            // ready about one cycle in eight, so the output FIFO fills and holds the sequencer
            ready_draw = (($random(seed) & 7) == 0);
            @(posedge wb_clk);
            #DRIVE_DELAY;
            out_ready_i = ready_draw;
        end
    end

    // compares every handshaked output word with the queue
    initial begin
        words_checked = 0;
        forever begin
            @(negedge wb_clk);
            if (!wb_rst && out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("an output word appeared at %0t ns with no record pending", $time);
                    $display("ERRORS FOUND");
                    $fatal(1, "unexpected output word");
                end else begin
                    check_value(field_name(words_checked % RECORD_WORDS), exp_q.pop_front(),
                                out_data_o);
                    words_checked++;
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge wb_clk);
            cycle_count++;
            if (cycle_count >= MAX_CYCLES) begin
                $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end
        end
    end

    //------------------------------------------------------
    // stimulus
    //------------------------------------------------------
    initial begin
        logic [1:0] code;
        word_t      adr;
        word_t      msk;
        word_t      dat;
        word_t      noise;
        wb_rst       = 1'b1;
        in_valid_i   = 1'b0;
        in_data_i    = '0;
        words_pushed = 0;
        for (int i = 0; i < 256; i++) begin
            mirror[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h33};  // slave's fill
        end
        repeat (RESET_CYCLES) @(posedge wb_clk);
        #DRIVE_DELAY;
        wb_rst = 1'b0;

        @(negedge wb_clk);  // idle outputs before any input
        check_value("in_ready_o", 32'd1, 32'(in_ready_o));
        check_value("out_valid_o", 32'd0, 32'(out_valid_o));
        check_value("wb_cyc_o", 32'd0, 32'(wb_cyc));
        check_value("wb_stb_o", 32'd0, 32'(wb_stb));
        @(posedge wb_clk);
        #DRIVE_DELAY;

        // write, read back, merge, read back with type code 3
        push_record(make_cmd(2'd1, 8'h11, 32'ha5a5_0000), 32'h0000_0040, '0, 32'h1234_5678);
        push_record(make_cmd(2'd0, 8'h12, 32'h7f00_0000), 32'h0000_0040, '0, '0);
        push_record(make_cmd(2'd2, 8'h21, 32'h0000_7ffc), 32'h0000_0040, 32'h00ff_ff00,
                    32'hcafe_babe);
        push_record(make_cmd(2'd3, 8'h22, 32'hff80_0000), 32'h0000_0040, '0, '0);
        // unmapped slot, then a normal read of the same index
        push_record(make_cmd(2'd0, 8'h31, 32'h0), 32'h8000_0010, '0, '0);
        push_record(make_cmd(2'd1, 8'h32, 32'h0), 32'h8000_0010, '0, 32'h5555_aaaa);
        push_record(make_cmd(2'd2, 8'h33, 32'h0), 32'h8000_0010, 32'hffff_ffff, 32'h0f0f_0f0f);
        push_record(make_cmd(2'd0, 8'h34, 32'h0), 32'h0000_0010, '0, '0);

        for (int n = 0; n < RANDOM_RECORDS; n++) begin
            code  = 2'($random(seed));
            adr   = $random(seed) & 32'h0000_003c;    // 16 words, so records hit each other
            if (($random(seed) & 7) == 0) adr[31] = 1'b1;
            msk   = $random(seed);
            dat   = $random(seed);
            noise = $random(seed);
            push_record(make_cmd(code, 8'(n), noise), adr, msk, dat);
        end

        while (words_checked < words_pushed) @(posedge wb_clk);
        repeat (5) @(posedge wb_clk);
        @(negedge wb_clk);
        if (exp_q.size() == 0 && words_checked == words_pushed && !out_valid_o) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("output stream has %0d of %0d words checked, or extra words",
                     words_checked, words_pushed);
            $display("ERRORS FOUND");
            $fatal(1, "output count mismatch");
        end
    end

endmodule

`default_nettype wire

/* wb_master.f */
verilog/wbm_pkg.sv
verilog/wbm_ifs.sv
verilog/word_fifo.sv
verilog/cmd_regs.sv
verilog/wb_cycle.sv
verilog/txn_sequencer.sv
verilog/wb_master_top.sv
tb/wb_mem_model.sv
tb/tb_wb_master.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_wb_master
FILELIST  = wb_master.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
